// File: Bender.yml
package:
  name: strided_stream_loader

sources:
  - include_dirs:
      - include
    files:
      - hw/sload_ctrl_pkg.sv
      - hw/sload_stream_pkg.sv
      - hw/sload_job_ctrl.sv
      - hw/sload_addrgen.sv
      - hw/sload_mem_reader.sv
      - hw/sload_top.sv
  - target: test
    files:
      - testbench/tb_sload_mem.sv
      - testbench/tb_sload.sv

// File: hw/sload_addrgen.sv
`timescale 1ns/1ps
`default_nettype none

`include "sload_config.svh"

module sload_addrgen (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         enable_i,    // walk while high
  input  logic                         clear_i,     // reset all counters
  input  logic                         presample_i, // first step, d0 offset kept at 0
  input  sload_ctrl_pkg::sload_cfg_t   cfg_i,
  output logic                         addr_valid_o,
  input  logic                         addr_ready_i,
  output sload_stream_pkg::sload_addr_t addr_o,
  output logic                         done_o       // all beats handed over
);

  import sload_ctrl_pkg::*;

  logic [2:0] dim_en; // job enables limited by hw mask
  logic       step;   // output slot free or draining
  logic       advance;

  sload_addr_t d0_off_q, d1_off_q, d2_off_q, d3_off_q;
  sload_addr_t d0_off_d, d1_off_d, d2_off_d, d3_off_d;
  sload_cnt_t  d0_cnt_q, d1_cnt_q, d2_cnt_q;
  sload_cnt_t  d0_cnt_d, d1_cnt_d, d2_cnt_d;
  sload_cnt_t  ov_cnt_q, ov_cnt_d; // beats issued so far
  logic        valid_q, valid_d;

  assign dim_en  = cfg_i.dim_enable_1h & `SLOAD_DIM_HW;
  assign step    = addr_ready_i || !valid_q;
  assign advance = (enable_i || presample_i) && step;

  // counters lead the emitted address by one step
  always_comb begin
    d0_off_d = d0_off_q;
    d1_off_d = d1_off_q;
    d2_off_d = d2_off_q;
    d3_off_d = d3_off_q;
    d0_cnt_d = d0_cnt_q;
    d1_cnt_d = d1_cnt_q;
    d2_cnt_d = d2_cnt_q;
    ov_cnt_d = ov_cnt_q;
    valid_d  = valid_q;
    if (ov_cnt_q < cfg_i.tot_len) begin
      valid_d = 1'b1;
      if ((d0_cnt_q < cfg_i.d0_len) || !dim_en[0]) begin
        d0_off_d = d0_off_q + sload_addr_t'(cfg_i.d0_stride); // innermost step
        d0_cnt_d = d0_cnt_q + 1'b1;
      end else if ((d1_cnt_q < cfg_i.d1_len) || !dim_en[1]) begin
        d0_off_d = '0;
        d1_off_d = d1_off_q + sload_addr_t'(cfg_i.d1_stride);
        d0_cnt_d = sload_cnt_t'(1);
        d1_cnt_d = d1_cnt_q + 1'b1;
      end else if ((d2_cnt_q < cfg_i.d2_len) || !dim_en[2]) begin
        d0_off_d = '0;
        d1_off_d = '0;
        d2_off_d = d2_off_q + sload_addr_t'(cfg_i.d2_stride);
        d0_cnt_d = sload_cnt_t'(1);
        d1_cnt_d = sload_cnt_t'(1);
        d2_cnt_d = d2_cnt_q + 1'b1;
      end else begin
        d0_off_d = '0; // inner dims exhausted
        d1_off_d = '0;
        d2_off_d = '0;
        d3_off_d = d3_off_q + sload_addr_t'(cfg_i.d3_stride); // unbounded
        d0_cnt_d = sload_cnt_t'(1);
        d1_cnt_d = sload_cnt_t'(1);
        d2_cnt_d = sload_cnt_t'(1);
      end
      ov_cnt_d = ov_cnt_q + 1'b1;
    end else begin
      valid_d = 1'b0; // last beat taken
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      d3_off_q <= '0;
      d0_cnt_q <= '0;
      d1_cnt_q <= sload_cnt_t'(1);
      d2_cnt_q <= sload_cnt_t'(1);
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
    end else if (clear_i) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      d3_off_q <= '0;
      d0_cnt_q <= '0; // first step counts beat 0
      d1_cnt_q <= sload_cnt_t'(1);
      d2_cnt_q <= sload_cnt_t'(1);
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
    end else if (advance) begin
      d0_off_q <= presample_i ? '0 : d0_off_d; // beat 0 sits at offset 0
      d1_off_q <= d1_off_d;
      d2_off_q <= d2_off_d;
      d3_off_q <= d3_off_d;
      d0_cnt_q <= d0_cnt_d;
      d1_cnt_q <= d1_cnt_d;
      d2_cnt_q <= d2_cnt_d;
      ov_cnt_q <= ov_cnt_d;
      valid_q  <= valid_d;
    end
  end

  assign addr_o       = cfg_i.base_addr + d3_off_q + d2_off_q + d1_off_q + d0_off_q;
  assign addr_valid_o = valid_q;
  assign done_o       = !valid_q && (ov_cnt_q >= cfg_i.tot_len); // nothing left to offer

  // stalled beat keeps its address
  addr_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (addr_valid_o && !addr_ready_i && !clear_i) |=> (addr_valid_o && $stable(addr_o))
  ) else $error("address changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/sload_ctrl_pkg.sv
`default_nettype none

`include "sload_config.svh"

package sload_ctrl_pkg;

  typedef logic [`SLOAD_ADDR_W-1:0] sload_addr_t;          // byte address
  typedef logic [`SLOAD_CNT_W-1:0] sload_cnt_t;            // lengths and beat counts
  typedef logic signed [`SLOAD_ADDR_W-1:0] sload_stride_t; // signed byte stride

  // job configuration, held on the job port for the whole request
  typedef struct packed {
    sload_addr_t   base_addr;     // first word of the pattern
    sload_cnt_t    tot_len;       // beats in the whole job
    sload_cnt_t    d0_len;        // beats per d0 run
    sload_cnt_t    d1_len;        // d0 runs per d1 run
    sload_cnt_t    d2_len;        // d1 runs per d2 run
    sload_stride_t d0_stride;
    sload_stride_t d1_stride;
    sload_stride_t d2_stride;
    sload_stride_t d3_stride;     // d3 never wraps
    logic [2:0]    dim_enable_1h; // 000 1-d, 001 2-d, 011 3-d, 111 4-d
  } sload_cfg_t;

  // job front end states
  typedef enum logic [2:0] {
    st_idle,  // waiting for req
    st_clear, // generator counters cleared
    st_start, // presample cycle
    st_run,   // generator walking
    st_drain, // walk done, reader still holding words
    st_ack    // ack high until req drops
  } sload_job_state_e;

endpackage

`default_nettype wire

// File: hw/sload_job_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sload_job_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       job_req_i,      // four-phase request
  input  sload_ctrl_pkg::sload_cfg_t job_cfg_i,      // stable while req high
  output logic                       job_ack_o,
  output sload_ctrl_pkg::sload_cfg_t cfg_o,          // latched copy for the job
  output logic                       gen_clear_o,    // one cycle
  output logic                       gen_presample_o, // one cycle
  output logic                       gen_enable_o,   // level while walking
  input  logic                       gen_done_i,     // walk finished
  input  logic                       rd_idle_i       // reader empty
);

  import sload_ctrl_pkg::*;

  sload_job_state_e state_q, state_d;
  sload_cfg_t       cfg_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:  if (job_req_i) state_d = st_clear; // sample req
      st_clear: state_d = st_start;
      st_start: state_d = st_run;
      st_run: begin
        if (gen_done_i && rd_idle_i) begin
          state_d = st_ack; // zero length jobs land here too
        end else if (gen_done_i) begin
          state_d = st_drain;
        end
      end
      st_drain: if (gen_done_i && rd_idle_i) state_d = st_ack; // last word left
      st_ack:   if (!job_req_i) state_d = st_idle; // ack drops next cycle
      default:  state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // config captured as the request is sampled
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && job_req_i) begin
      cfg_q <= job_cfg_i;
    end
  end

  assign cfg_o           = cfg_q;
  assign gen_clear_o     = (state_q == st_clear);
  assign gen_presample_o = (state_q == st_start);
  assign gen_enable_o    = (state_q == st_run);
  assign job_ack_o       = (state_q == st_ack); // registered through state

  // requester must not touch the config before ack
  cfg_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (job_req_i && !job_ack_o) |=> (!job_req_i || job_ack_o || $stable(job_cfg_i))
  ) else $error("job_cfg_i changed during an open request");

endmodule

`default_nettype wire

// File: hw/sload_mem_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "sload_config.svh"

module sload_mem_reader (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            addr_valid_i,
  output logic                            addr_ready_o,
  input  sload_stream_pkg::sload_addr_t   addr_i,
  output sload_stream_pkg::sload_mem_req_t mem_req_o,
  input  sload_stream_pkg::sload_mem_rsp_t mem_rsp_i,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output sload_stream_pkg::sload_data_t   out_data_o,
  output logic                            idle_o      // nothing pending or buffered
);

  import sload_stream_pkg::*;

  localparam int unsigned RdDepth = `SLOAD_RD_DEPTH;
  localparam int unsigned CntW    = $clog2(RdDepth + 1);
  localparam int unsigned PtrW    = (RdDepth > 1) ? $clog2(RdDepth) : 1;

  logic            accept, pop;
  logic [CntW-1:0] credit_q; // accepted but not yet popped
  logic [CntW-1:0] buf_cnt_q; // words sitting in the buffer
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic            req_q;
  sload_addr_t     req_addr_q;
  sload_data_t     buf_q [RdDepth];

  // request slot free or leaving this cycle, and room for the word
  assign addr_ready_o = (credit_q < CntW'(RdDepth)) && (!req_q || mem_rsp_i.gnt);
  assign accept       = addr_valid_i && addr_ready_o;
  assign pop          = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      credit_q <= '0;
    end else begin
      if (accept) begin
        req_q <= 1'b1;
      end else if (mem_rsp_i.gnt) begin
        req_q <= 1'b0; // granted, word in flight
      end
      case ({accept, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= addr_i; // held until gnt
    end
  end

  // circular buffer, written by rvalid, read by pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      buf_cnt_q <= '0;
    end else begin
      if (mem_rsp_i.rvalid) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RdDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RdDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({mem_rsp_i.rvalid, pop})
        2'b10:   buf_cnt_q <= buf_cnt_q + 1'b1;
        2'b01:   buf_cnt_q <= buf_cnt_q - 1'b1;
        default: buf_cnt_q <= buf_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) begin
      buf_q[wr_ptr_q] <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_o.req  = req_q;
  assign mem_req_o.addr = req_addr_q;
  assign out_valid_o    = (buf_cnt_q != '0);
  assign out_data_o     = buf_q[rd_ptr_q]; // oldest word
  assign idle_o         = (credit_q == '0);

  // credits keep the buffer from overflowing
  no_overflow_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.rvalid |-> (buf_cnt_q < CntW'(RdDepth))
  ) else $error("read word arrived with a full buffer");

endmodule

`default_nettype wire

// File: hw/sload_stream_pkg.sv
`default_nettype none

`include "sload_config.svh"

package sload_stream_pkg;

  typedef logic [`SLOAD_DATA_W-1:0] sload_data_t; // memory word

  // address beat on the internal stream, same vector as the job address
  typedef sload_ctrl_pkg::sload_addr_t sload_addr_t;

  // read request toward memory
  typedef struct packed {
    logic        req;  // held until gnt
    sload_addr_t addr; // word aligned byte address
  } sload_mem_req_t;

  // memory answer, rvalid one cycle after gnt
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    sload_data_t rdata;
  } sload_mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/sload_top.sv
`timescale 1ns/1ps
`default_nettype none

module sload_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             job_req_i,
  input  sload_ctrl_pkg::sload_cfg_t       job_cfg_i,
  output logic                             job_ack_o,
  output sload_stream_pkg::sload_mem_req_t mem_req_o,
  input  sload_stream_pkg::sload_mem_rsp_t mem_rsp_i,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output sload_stream_pkg::sload_data_t    out_data_o
);

  import sload_ctrl_pkg::*;

  sload_cfg_t  cfg;          // latched job config
  logic        gen_clear;
  logic        gen_presample;
  logic        gen_enable;
  logic        gen_done;
  logic        rd_idle;
  logic        addr_valid;   // address stream
  logic        addr_ready;
  sload_addr_t addr;

  sload_job_ctrl i_job_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .job_req_i       (job_req_i),
    .job_cfg_i       (job_cfg_i),
    .job_ack_o       (job_ack_o),
    .cfg_o           (cfg),
    .gen_clear_o     (gen_clear),
    .gen_presample_o (gen_presample),
    .gen_enable_o    (gen_enable),
    .gen_done_i      (gen_done),
    .rd_idle_i       (rd_idle)
  );

  sload_addrgen i_addrgen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (gen_enable),
    .clear_i      (gen_clear),
    .presample_i  (gen_presample),
    .cfg_i        (cfg),
    .addr_valid_o (addr_valid),
    .addr_ready_i (addr_ready),
    .addr_o       (addr),
    .done_o       (gen_done)
  );

  sload_mem_reader i_mem_reader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_valid_i (addr_valid),
    .addr_ready_o (addr_ready),
    .addr_i       (addr),
    .mem_req_o    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_data_o   (out_data_o),
    .idle_o       (rd_idle)
  );

endmodule

`default_nettype wire

// File: include/sload_config.svh
`ifndef SLOAD_CONFIG_SVH
`define SLOAD_CONFIG_SVH

// byte address width
`define SLOAD_ADDR_W 32

// memory word width
`define SLOAD_DATA_W 32

// length and beat counter width
`define SLOAD_CNT_W 16

// dimensions that may be enabled in hardware, d1/d2/d3 nesting
`define SLOAD_DIM_HW 3'b111

// words buffered plus in flight in the reader
`define SLOAD_RD_DEPTH 2

`endif

// File: strided_stream_loader.f
+incdir+include
hw/sload_ctrl_pkg.sv
hw/sload_stream_pkg.sv
hw/sload_job_ctrl.sv
hw/sload_addrgen.sv
hw/sload_mem_reader.sv
hw/sload_top.sv
testbench/tb_sload_mem.sv
testbench/tb_sload.sv

// File: testbench/tb_sload.sv
`timescale 1ns/1ps
`default_nettype none

`include "sload_config.svh"

module tb_sload;

  import sload_ctrl_pkg::*;

  localparam logic [31:0] xor_pattern = 32'hc3a5_5a3c;
  localparam int total_beats = 12 + 9 + 30 + 0; // all jobs below
  localparam int num_jobs    = 4;
  localparam int cycle_limit = 8 * total_beats + 50 * num_jobs;

  logic clk_i, rst_ni, job_req, job_ack, out_valid, out_ready, gnt_en;
  sload_cfg_t                       job_cfg;
  sload_stream_pkg::sload_mem_req_t mem_req;
  sload_stream_pkg::sload_mem_rsp_t mem_rsp;
  sload_stream_pkg::sload_data_t    out_data;
  logic [31:0] lfsr_q = 32'h6bfa_392f; // stall source
  logic [31:0] exp_q [$];             // expected words of the open job
  string       cur_name = "reset";
  int          beat_cnt, cycle_cnt;

  sload_top uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .job_req_i   (job_req),
    .job_cfg_i   (job_cfg),
    .job_ack_o   (job_ack),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_data_o  (out_data)
  );

  tb_sload_mem #(.xor_pattern (xor_pattern)) i_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .gnt_en_i  (gnt_en),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0); // galois, taps 32 22 2 1
  endfunction

  // expected byte address of beat idx by the nesting rule
  function automatic logic [31:0] ref_addr(input sload_cfg_t c, input int unsigned idx);
    logic [2:0]  en;
    logic [31:0] o0, o1, o2, o3;
    int unsigned c0, c1, c2;
    en = c.dim_enable_1h & `SLOAD_DIM_HW;
    o0 = '0;
    o1 = '0;
    o2 = '0;
    o3 = '0;
    c0 = 1; // beat 0 at offset 0
    c1 = 1;
    c2 = 1;
    for (int unsigned i = 0; i < idx; i++) begin
      if (c0 < c.d0_len || !en[0]) begin
        o0 += c.d0_stride;
        c0++;
      end else if (c1 < c.d1_len || !en[1]) begin
        o0 = '0;
        c0 = 1;
        o1 += c.d1_stride;
        c1++;
      end else if (c2 < c.d2_len || !en[2]) begin
        o0 = '0;
        o1 = '0;
        c0 = 1;
        c1 = 1;
        o2 += c.d2_stride;
        c2++;
      end else begin
        o0 = '0;
        o1 = '0;
        o2 = '0;
        c0 = 1;
        c1 = 1;
        c2 = 1;
        o3 += c.d3_stride; // d3 never wraps
      end
    end
    return c.base_addr + o0 + o1 + o2 + o3;
  endfunction

  function automatic sload_cfg_t make_cfg(input logic [31:0] base, input int tot, l0, l1, l2,
                                          input int s0, s1, s2, s3, input logic [2:0] en);
    sload_cfg_t c;
    c.base_addr     = base;
    c.tot_len       = tot;
    c.d0_len        = l0;
    c.d1_len        = l1;
    c.d2_len        = l2;
    c.d0_stride     = s0;
    c.d1_stride     = s1;
    c.d2_stride     = s2;
    c.d3_stride     = s3;
    c.dim_enable_1h = en;
    return c;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  // one four-phase job with checks on the ack sequence
  task automatic run_job(input string name, input sload_cfg_t c);
    for (int unsigned i = 0; i < c.tot_len; i++) begin
      exp_q.push_back(ref_addr(c, i) ^ xor_pattern);
    end
    cur_name = name;
    beat_cnt = 0;
    @(posedge clk_i);
    job_cfg <= c;
    job_req <= 1'b1;
    do @(negedge clk_i); while (!job_ack);
    check_eq({name, " beats at ack"}, c.tot_len, beat_cnt); // last beat already taken
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq({name, " ack held"}, 1, job_ack);
    @(posedge clk_i);
    job_req <= 1'b0;
    @(negedge clk_i);
    check_eq({name, " ack after req drop"}, 1, job_ack); // drops a cycle later
    @(negedge clk_i);
    check_eq({name, " ack low"}, 0, job_ack);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    lfsr_q = lfsr_step(lfsr_q);
    out_ready <= lfsr_q[0]; // one bit per step
    lfsr_q = lfsr_step(lfsr_q);
    gnt_en <= lfsr_q[0];
  end

  // output stream checker, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        stop_on_error($sformatf("%s: output beat with no beat expected", cur_name));
      end else begin
        check_eq(cur_name, exp_q.pop_front(), out_data);
        beat_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      stop_on_error($sformatf("timeout after %0d cycles in job %s", cycle_cnt, cur_name));
    end
  end

  initial begin
    rst_ni    = 1'b0;
    job_req   = 1'b0;
    job_cfg   = '0;
    out_ready = 1'b0;
    gnt_en    = 1'b0;
    cycle_cnt = 0;
    beat_cnt  = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_eq("reset ack", 0, job_ack);
    check_eq("reset valid", 0, out_valid);
    check_eq("reset mem req", 0, mem_req.req);
    run_job("1d_linear", make_cfg(32'h0000_1000, 12, 0, 0, 0, 4, 0, 0, 0, 3'b000));
    run_job("2d_wrap", make_cfg(32'h0000_4000, 9, 3, 0, 0, 4, 64, 0, 0, 3'b001));
    run_job("4d_neg_stride", make_cfg(32'h0000_8000, 30, 2, 3, 2, 4, 32, -256, 4096, 3'b111));
    run_job("zero_len", make_cfg(32'h0000_c000, 0, 4, 4, 4, 4, 16, 64, 256, 3'b111));
    check_eq("leftover beats", 0, exp_q.size());
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_sload_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sload_mem #(
  parameter sload_stream_pkg::sload_data_t xor_pattern = 32'hc3a5_5a3c // word = addr ^ pattern
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             gnt_en_i,  // random grant permission
  input  sload_stream_pkg::sload_mem_req_t mem_req_i,
  output sload_stream_pkg::sload_mem_rsp_t mem_rsp_o
);

  import sload_stream_pkg::*;

  logic        gnt;
  logic        rvalid_q; // answer one cycle after grant
  sload_data_t rdata_q;

  assign gnt = mem_req_i.req && gnt_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= mem_req_i.addr ^ xor_pattern; // word derived from address
    end
  end

  assign mem_rsp_o.gnt    = gnt;
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

endmodule

`default_nettype wire
